//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ifu_top
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= Test failures found
PASS_MSG  ?= All tests passed!

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- build.f
common/ifu_pkg.sv
icache/icache_bank.sv
icache/icache_tags.sv
icache/icache_data.sv
rtl/ifu_fetch_ctrl.sv
rtl/ifu_top.sv
verif/ifu_assert.sv
verif/tb_ifu_top.sv

//--- common/ifu_pkg.sv
package ifu_pkg;

    // Widths and sizes.
    localparam int PC_W       = 64;
    localparam int AXI_ADDR_W = 32;
    localparam int AXI_DATA_W = 64;
    localparam int INST_W     = 32;
    localparam int NUM_WAYS   = 8;
    localparam int NUM_SETS   = 64;
    localparam int NUM_BANKS  = 4;
    localparam int BANK_W     = 128;

    // PC fields: tag | index | offset.
    localparam int OFFSET_W  = 3;
    localparam int INDEX_W   = 6;
    localparam int TAG_W     = 55;
    localparam int INDEX_LSB = OFFSET_W;
    localparam int TAG_LSB   = OFFSET_W + INDEX_W;

    // Cacheable region, on the low 32 address bits.
    localparam logic [AXI_ADDR_W-1:0] CACHE_BASE  = 32'h8000_0000;
    localparam logic [AXI_ADDR_W-1:0] CACHE_LIMIT = 32'h8FFF_FFFF;

    // AXI response and size codes.
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_EXOKAY = 2'b01;
    localparam logic [2:0] SIZE_WORD   = 3'd2;
    localparam logic [2:0] SIZE_DWORD  = 3'd3;

    typedef logic [PC_W-1:0]       pc_t;
    typedef logic [INST_W-1:0]     inst_t;
    typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
    typedef logic [AXI_DATA_W-1:0] axi_data_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [2:0]            way_t;
    typedef logic [BANK_W-1:0]     bank_word_t;

    typedef enum logic [2:0] {
        IDLE,
        READ_CACHE,
        AR,
        R,
        FILL,
        DONE
    } fetch_state_e;

endpackage

//--- icache/icache_bank.sv
module icache_bank import ifu_pkg::*; (
    input  logic       clk,
    input  index_t     addr,
    input  logic       cen,
    input  logic       wen,
    input  bank_word_t wmask,
    input  bank_word_t wdata,
    output bank_word_t rdata
);

    bank_word_t mem [NUM_SETS];

    // Read returns the old word when writing the same entry.
    always_ff @(posedge clk) begin
        if (!cen) begin
            if (!wen) begin
                mem[addr] <= (mem[addr] & ~wmask) | (wdata & wmask);
            end
            rdata <= mem[addr];
        end
    end

endmodule

//--- icache/icache_data.sv
module icache_data import ifu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  pc_t       pc,
    input  logic      fill,
    input  way_t      fill_way,
    input  axi_data_t fill_data,
    input  way_t      hit_way,
    output axi_data_t cache_line
);

    index_t     index;
    logic       bank_cen;
    bank_word_t wmask;
    bank_word_t wdata;
    logic       bank_wen   [NUM_BANKS];
    bank_word_t bank_rdata [NUM_BANKS];
    bank_word_t hit_word;

    assign index = pc[INDEX_LSB +: INDEX_W];

    // Banks are idle while in reset.
    assign bank_cen = rst;

    // Even ways live in the low half of a bank, odd ways in the high half.
    assign wmask = fill_way[0] ? {{AXI_DATA_W{1'b1}}, {AXI_DATA_W{1'b0}}}
                               : {{AXI_DATA_W{1'b0}}, {AXI_DATA_W{1'b1}}};
    assign wdata = fill_way[0] ? {fill_data, {AXI_DATA_W{1'b0}}}
                               : {{AXI_DATA_W{1'b0}}, fill_data};

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        assign bank_wen[b] = !(fill && (fill_way[2:1] == 2'(b)));

        icache_bank u_bank (
            .clk   (clk),
            .addr  (index),
            .cen   (bank_cen),
            .wen   (bank_wen[b]),
            .wmask (wmask),
            .wdata (wdata),
            .rdata (bank_rdata[b])
        );
    end

    assign hit_word   = bank_rdata[hit_way[2:1]];
    assign cache_line = hit_way[0] ? hit_word[BANK_W-1:AXI_DATA_W] : hit_word[AXI_DATA_W-1:0];

endmodule

//--- icache/icache_tags.sv
module icache_tags import ifu_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  pc_t  pc,
    input  logic fill,
    input  logic fence_i,
    output logic hit,
    output way_t hit_way,
    output way_t fill_way
);

    index_t              index;
    tag_t                tag;
    logic [NUM_WAYS-1:0] valid [NUM_SETS];
    tag_t                tags  [NUM_WAYS][NUM_SETS];
    logic [NUM_WAYS-1:0] set_valid;
    logic [NUM_WAYS-1:0] way_hit;

    assign index     = pc[INDEX_LSB +: INDEX_W];
    assign tag       = pc[TAG_LSB +: TAG_W];
    assign set_valid = valid[index];

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = set_valid[w] && (tags[w][index] == tag);
        end
    end

    assign hit = |way_hit;

    // Lowest matching way.
    always_comb begin
        hit_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (way_hit[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    // First invalid way, way 0 when the set is full.
    always_comb begin
        fill_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!set_valid[w]) begin
                fill_way = way_t'(w);
            end
        end
    end

    // A fill in progress takes priority over fence.i.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid[s] <= '0;
            end
        end else if (fill) begin
            valid[index][fill_way] <= 1'b1;
        end else if (fence_i) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid[s] <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tags[fill_way][index] <= tag;
        end
    end

endmodule

//--- rtl/ifu_fetch_ctrl.sv
module ifu_fetch_ctrl import ifu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  pc_t        pc,
    input  logic       fetch_en,
    input  logic       id_ready,
    input  logic       hit,
    input  axi_data_t  cache_line,

    output logic       arvalid,
    output axi_addr_t  araddr,
    output logic [2:0] arsize,
    input  logic       arready,

    output logic       rready,
    input  logic       rvalid,
    input  axi_data_t  rdata,
    input  logic [1:0] rresp,
    input  logic       rlast,

    output logic       fill,
    output axi_data_t  fill_data,
    output inst_t      inst,
    output logic       inst_valid,
    output logic       fetch_done
);

    fetch_state_e state;
    fetch_state_e state_next;
    axi_addr_t    pc_lo;
    logic         cacheable;
    logic         beat_ok;
    axi_data_t    refill_buf;
    axi_data_t    line;

    assign pc_lo     = pc[AXI_ADDR_W-1:0];
    assign cacheable = (pc_lo >= CACHE_BASE) && (pc_lo <= CACHE_LIMIT);

    // Single-beat read, error responses are not taken.
    assign beat_ok = rvalid && rlast && ((rresp == RESP_OKAY) || (rresp == RESP_EXOKAY));

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (fetch_en) begin
                    if (cacheable && hit) begin
                        state_next = READ_CACHE;
                    end else begin
                        state_next = AR;
                    end
                end
            end
            READ_CACHE: begin
                state_next = DONE;
            end
            AR: begin
                if (arready) begin
                    state_next = R;
                end
            end
            R: begin
                if (beat_ok) begin
                    state_next = cacheable ? FILL : DONE;
                end
            end
            FILL: begin
                // Line is written, read it back from the banks.
                state_next = READ_CACHE;
            end
            DONE: begin
                if (id_ready) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rready && beat_ok) begin
            refill_buf <= rdata;
        end
    end

    assign arvalid = (state == AR);
    assign rready  = (state == R);
    assign araddr  = cacheable ? {pc_lo[AXI_ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}} : pc_lo;
    assign arsize  = cacheable ? SIZE_DWORD : SIZE_WORD;

    assign fill      = (state == FILL);
    assign fill_data = refill_buf;

    // Uncached words come from the refill buffer.
    assign line = hit ? cache_line : refill_buf;
    assign inst = pc[2] ? line[2*INST_W-1:INST_W] : line[INST_W-1:0];

    assign inst_valid = (state == DONE);
    assign fetch_done = (state == DONE) && id_ready;

endmodule

//--- rtl/ifu_top.sv
module ifu_top import ifu_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    input  pc_t       pc,
    input  logic      fetch_en,
    input  logic      fence_i,
    input  logic      id_ready,
    output inst_t     inst,
    output logic      inst_valid,
    output logic      fetch_done,

    output logic      arvalid,
    output axi_addr_t araddr,
    output logic [2:0] arsize,
    input  logic      arready,

    output logic      rready,
    input  logic      rvalid,
    input  axi_data_t rdata,
    input  logic [1:0] rresp,
    input  logic      rlast
);

    logic      hit;
    way_t      hit_way;
    way_t      fill_way;
    logic      fill;
    axi_data_t fill_data;
    axi_data_t cache_line;

    ifu_fetch_ctrl u_fetch_ctrl (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .fetch_en   (fetch_en),
        .id_ready   (id_ready),
        .hit        (hit),
        .cache_line (cache_line),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arsize     (arsize),
        .arready    (arready),
        .rready     (rready),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .rresp      (rresp),
        .rlast      (rlast),
        .fill       (fill),
        .fill_data  (fill_data),
        .inst       (inst),
        .inst_valid (inst_valid),
        .fetch_done (fetch_done)
    );

    icache_tags u_tags (
        .clk      (clk),
        .rst      (rst),
        .pc       (pc),
        .fill     (fill),
        .fence_i  (fence_i),
        .hit      (hit),
        .hit_way  (hit_way),
        .fill_way (fill_way)
    );

    icache_data u_data (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .fill       (fill),
        .fill_way   (fill_way),
        .fill_data  (fill_data),
        .hit_way    (hit_way),
        .cache_line (cache_line)
    );

endmodule

//--- verif/ifu_assert.sv
module ifu_assert import ifu_pkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       arvalid,
    input logic       arready,
    input axi_addr_t  araddr,
    input logic [2:0] arsize,
    input logic       rready,
    input inst_t      inst,
    input logic       inst_valid,
    input logic       id_ready
);

    int fail_count = 0;

    // Address request holds until the memory takes it.
    ar_hold: assert property (
        @(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arsize)
    ) else begin
        $error("AR request changed before arready");
        fail_count++;
    end

    // Read phase opens only after an accepted address.
    r_after_ar: assert property (
        @(posedge clk) disable iff (rst)
        rready |-> !arvalid && $past(rready || (arvalid && arready))
    ) else begin
        $error("rready without an accepted AR request");
        fail_count++;
    end

    // Decode stall keeps the word in place.
    inst_hold: assert property (
        @(posedge clk) disable iff (rst)
        inst_valid && !id_ready |=> inst_valid && $stable(inst)
    ) else begin
        $error("inst changed while decode stalled");
        fail_count++;
    end

endmodule

//--- verif/tb_ifu_top.sv
module tb_ifu_top import ifu_pkg::*; ();

    localparam int  WAIT_LIMIT = 200;
    localparam int  NUM_HOLDS  = 3;
    localparam pc_t HIT_PC     = 64'h0000_0000_8000_1008;

    logic       clk;
    logic       rst;
    pc_t        pc;
    logic       fetch_en;
    logic       fence_i;
    logic       id_ready;
    inst_t      inst;
    logic       inst_valid;
    logic       fetch_done;
    logic       arvalid;
    axi_addr_t  araddr;
    logic [2:0] arsize;
    logic       arready;
    logic       rready;
    logic       rvalid;
    axi_data_t  rdata;
    logic [1:0] rresp;
    logic       rlast;

    logic [31:0] lfsr_state   = 32'h8693_5810;
    int          errors       = 0;
    int          checks       = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    int          fetch_count  = 0;
    int          done_count   = 0;
    int          ar_count     = 0;
    axi_addr_t   last_araddr  = '0;
    logic [2:0]  last_arsize  = '0;

    ifu_top u_ifu_top (
        .clk(clk), .rst(rst), .pc(pc), .fetch_en(fetch_en), .fence_i(fence_i),
        .id_ready(id_ready), .inst(inst), .inst_valid(inst_valid), .fetch_done(fetch_done),
        .arvalid(arvalid), .araddr(araddr), .arsize(arsize), .arready(arready),
        .rready(rready), .rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rlast(rlast)
    );

    bind ifu_fetch_ctrl ifu_assert u_ifu_assert (
        .clk(clk), .rst(rst), .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .arsize(arsize), .rready(rready), .inst(inst), .inst_valid(inst_valid),
        .id_ready(id_ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic int unsigned draw_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Memory contents: a fixed hash of the word address.
    function automatic inst_t ref_inst(input axi_addr_t addr);
        logic [31:0] h;
        h = {addr[31:2], 2'b00} ^ 32'h2545_F491;
        h = h * 32'h9E37_79B1;
        h = h ^ (h >> 15);
        h = h * 32'h85EB_CA6B;
        h = h ^ (h >> 13);
        return h;
    endfunction

    function automatic logic in_region(input pc_t p);
        return (p[31:0] >= CACHE_BASE) && (p[31:0] <= CACHE_LIMIT);
    endfunction

    // Same index 5 for every tag number.
    function automatic pc_t repl_pc(input int t);
        return 64'h0000_0000_8000_0028 + (64'(t) << TAG_LSB) + (64'(t & 1) << 2);
    endfunction

    task automatic check_inst(input string name, input inst_t got, input inst_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input axi_addr_t got, input axi_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_size(input string name, input logic [2:0] got, input logic [2:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("[FAIL] t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic abort_run(input string why);
        $display("[ERROR] t=%0t %s", $time, why);
        $display("Test failures found");
        $finish;
    endtask

    // Simple AXI slave with random stalls on both channels.
    initial begin : axi_memory
        int unsigned ar_left;
        int unsigned r_left;
        logic        ar_armed;
        logic        r_pending;
        axi_addr_t   line_addr;
        ar_left   = 0;
        r_left    = 0;
        ar_armed  = 1'b0;
        r_pending = 1'b0;
        line_addr = '0;
        arready <= 1'b0;
        rvalid  <= 1'b0;
        rdata   <= '0;
        rresp   <= RESP_OKAY;
        rlast   <= 1'b0;
        forever begin
            @(posedge clk);
            if (rst) begin
                arready <= 1'b0;
                rvalid  <= 1'b0;
                rlast   <= 1'b0;
                ar_armed  = 1'b0;
                r_pending = 1'b0;
            end else begin
                if (arvalid && arready) begin
                    ar_count++;
                    last_araddr = araddr;
                    last_arsize = arsize;
                    line_addr = {araddr[31:3], 3'b000};
                    arready <= 1'b0;
                    ar_armed  = 1'b0;
                    r_pending = 1'b1;
                    r_left    = draw_bits(2);
                end else if (arvalid) begin
                    if (!ar_armed) begin
                        ar_left  = draw_bits(2);
                        ar_armed = 1'b1;
                    end
                    if (ar_left == 0) begin
                        arready <= 1'b1;
                    end else begin
                        ar_left--;
                    end
                end
                if (rvalid && rready) begin
                    rvalid <= 1'b0;
                    rlast  <= 1'b0;
                end else if (r_pending) begin
                    if (r_left == 0) begin
                        rvalid <= 1'b1;
                        rdata  <= {ref_inst(line_addr + 32'd4), ref_inst(line_addr)};
                        rresp  <= RESP_OKAY;
                        rlast  <= 1'b1;
                        r_pending = 1'b0;
                    end else begin
                        r_left--;
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && fetch_done) begin
            done_count++;
            check_inst("inst", inst, ref_inst(pc[31:0]));
        end
    end

    task automatic run_fetch(input pc_t addr, input logic exp_miss, input int hold);
        int    ar_before;
        int    lat;
        int    wait_n;
        inst_t held;
        ar_before = ar_count;
        fetch_count++;
        pc       <= addr;
        fetch_en <= 1'b1;
        id_ready <= (hold == 0);
        @(posedge clk);
        fetch_en <= 1'b0;
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
        end while (!inst_valid && lat < WAIT_LIMIT);
        if (!inst_valid) begin
            abort_run($sformatf("inst_valid never rose for pc %h", addr));
        end
        if (hold > 0) begin
            held = inst;
            for (int i = 0; i < hold; i++) begin
                check_count("fetch_done", int'(fetch_done), 0);
                check_inst("inst held", inst, held);
                @(posedge clk);
            end
            id_ready <= 1'b1;
            wait_n = 0;
            do begin
                @(posedge clk);
                wait_n++;
            end while (!fetch_done && wait_n < WAIT_LIMIT);
            if (!fetch_done) begin
                abort_run($sformatf("fetch_done never rose after stall, pc %h", addr));
            end
        end else begin
            check_count("fetch_done", int'(fetch_done), 1);
        end
        if (exp_miss) begin
            check_count("ar count", ar_count - ar_before, 1);
            check_addr("araddr", last_araddr,
                       in_region(addr) ? {addr[31:3], 3'b000} : addr[31:0]);
            check_size("arsize", last_arsize, in_region(addr) ? SIZE_DWORD : SIZE_WORD);
        end else begin
            check_count("ar count", ar_count - ar_before, 0);
            check_count("inst_valid latency", lat, 2);
        end
        @(posedge clk);
    endtask

    task automatic miss_then_hit();
        run_fetch(HIT_PC, 1'b1, 0);
        run_fetch(HIT_PC, 1'b0, 0);
        run_fetch(HIT_PC | 64'h4, 1'b0, 0);
    endtask

    task automatic uncached_fetches();
        for (int i = 0; i < 2; i++) begin
            run_fetch(64'h0000_0000_0000_2004, 1'b1, 0);
            run_fetch(64'h0000_0000_9000_0010, 1'b1, 0);
            run_fetch(64'h0000_0000_7FFF_FFF8, 1'b1, 0);
        end
    endtask

    task automatic way_replacement();
        for (int t = 1; t <= 8; t++) begin
            run_fetch(repl_pc(t), 1'b1, 0);
        end
        for (int t = 1; t <= 8; t++) begin
            run_fetch(repl_pc(t), 1'b0, 0);
        end
        // Full set, the ninth tag lands in way 0.
        run_fetch(repl_pc(9), 1'b1, 0);
        for (int t = 2; t <= 8; t++) begin
            run_fetch(repl_pc(t), 1'b0, 0);
        end
        run_fetch(repl_pc(1), 1'b1, 0);
    endtask

    task automatic fence_invalidate();
        run_fetch(HIT_PC, 1'b0, 0);
        fence_i <= 1'b1;
        @(posedge clk);
        fence_i <= 1'b0;
        run_fetch(HIT_PC, 1'b1, 0);
        run_fetch(HIT_PC, 1'b0, 0);
        run_fetch(repl_pc(2), 1'b1, 0);
    endtask

    task automatic decode_backpressure(input int h0, input int h1, input int h2);
        run_fetch(HIT_PC, 1'b0, h0);
        run_fetch(64'h0000_0000_8000_2010, 1'b1, h1);
        run_fetch(64'h0000_0000_0000_3004, 1'b1, h2);
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("[test %0d] %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("[test %0d] %s: %0d errors", tests_run, name, errors - errs_before);
        end
    endtask

    initial begin : stimulus
        int hold [NUM_HOLDS];
        int errs;
        int assert_fails;
        rst      <= 1'b1;
        pc       <= '0;
        fetch_en <= 1'b0;
        fence_i  <= 1'b0;
        id_ready <= 1'b1;
        for (int i = 0; i < NUM_HOLDS; i++) begin
            hold[i] = 1 + draw_bits(3);
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        errs = errors;
        miss_then_hit();
        report_test("miss then hit", errs);
        errs = errors;
        uncached_fetches();
        report_test("uncached fetch", errs);
        errs = errors;
        way_replacement();
        report_test("way replacement", errs);
        errs = errors;
        fence_invalidate();
        report_test("fence.i invalidate", errs);
        errs = errors;
        decode_backpressure(hold[0], hold[1], hold[2]);
        report_test("decode back-pressure", errs);

        repeat (2) @(posedge clk);
        check_count("completed fetches", done_count, fetch_count);
        assert_fails = u_ifu_top.u_fetch_ctrl.u_ifu_assert.fail_count;
        errors = errors + assert_fails;
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d assertion failures, %0d errors",
                 tests_run, tests_failed, checks, assert_fails, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
